/* lanes_pkg.sv */
// Lane bundle shared definitions
// Bundle constants, packet structs and the lane state encoding
package lanes_pkg;

    // ------------------------------------------------
    // Bundle constants
    // ------------------------------------------------
    localparam int NUM_LANES   = 4;
    localparam int LANE_ID_W   = 2;
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int COUNT_W     = 8;

    // Both top-level FIFOs
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 12;

    // Address layout of the lane request runs
    localparam logic [ADDR_W-1:0] LANE_STRIDE = 32'h1000;
    localparam logic [ADDR_W-1:0] WORD_BYTES  = 32'd4;

    // ------------------------------------------------
    // Scalar types
    // ------------------------------------------------
    typedef logic [LANE_ID_W-1:0] lane_id_t;
    typedef logic [ADDR_W-1:0]    mem_addr_t;
    typedef logic [DATA_W-1:0]    mem_data_t;

    // ------------------------------------------------
    // Packets
    // ------------------------------------------------
    // Kernel descriptor, one-cycle strobe
    typedef struct packed {
        logic               valid;
        mem_addr_t          base;
        logic [COUNT_W-1:0] count;
    } descriptor_t;

    // Read request, tagged with the issuing lane
    typedef struct packed {
        logic      valid;
        lane_id_t  id;
        mem_addr_t addr;
    } mem_request_t;

    // Read response, routed back by id
    typedef struct packed {
        logic      valid;
        lane_id_t  id;
        mem_data_t data;
    } mem_response_t;

    // Lane request generator states
    typedef enum logic [1:0] {
        LANE_IDLE  = 2'd0,
        LANE_ISSUE = 2'd1,
        LANE_WAIT  = 2'd2,
        LANE_DONE  = 2'd3
    } lane_state_e;

endpackage : lanes_pkg

/* sync_fifo.sv */
// Synchronous FIFO
// Registered read data with a one-cycle valid, plus empty, full and prog_full
`timescale 1ns/1ns

module sync_fifo #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 32
) (
    input  logic             ap_clk,
    input  logic             areset_lanes,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    logic [WIDTH-1:0]             mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic                         do_write;
    logic                         do_read;

    // Overflow and underflow are dropped here
    assign do_write  = wr_en && !full;
    assign do_read   = rd_en && !empty;

    // Flags straight off the occupancy register
    assign empty     = (count == '0);
    assign full      = (count == DEPTH);
    assign prog_full = (count >= lanes_pkg::PROG_THRESH);

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // Net change of one at most per cycle
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (!do_write && do_read) begin
                count <= count - 1'b1;
            end
            valid <= do_read;
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
        if (do_read) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : sync_fifo

/* lane_engine.sv */
// Lane request generator
// Turns the broadcast descriptor into a run of tagged reads and counts responses
`timescale 1ns/1ns

module lane_engine #(
    parameter lanes_pkg::lane_id_t LANE_ID = '0
) (
    input  logic                    ap_clk,
    input  logic                    areset_lanes,
    input  lanes_pkg::descriptor_t  descriptor,
    output lanes_pkg::mem_request_t request,
    input  logic                    grant,
    input  lanes_pkg::mem_response_t response,
    output logic                    lane_busy,
    output logic                    lane_done
);

    lanes_pkg::lane_state_e       state;
    lanes_pkg::mem_addr_t         addr_reg;
    logic [lanes_pkg::COUNT_W-1:0] total;
    logic [lanes_pkg::COUNT_W-1:0] issued;
    logic [lanes_pkg::COUNT_W-1:0] received;
    logic                         idle_like;
    logic                         accept;
    logic                         resp_hit;

    // Free to take a new descriptor
    assign idle_like = (state == lanes_pkg::LANE_IDLE) || (state == lanes_pkg::LANE_DONE);
    assign accept    = idle_like && descriptor.valid;
    // Only responses tagged for this lane count
    assign resp_hit  = response.valid && (response.id == LANE_ID);

    // ------------------------------------------------
    // Outputs
    // ------------------------------------------------
    // Request held as a level through ISSUE
    assign request.valid = (state == lanes_pkg::LANE_ISSUE);
    assign request.id    = LANE_ID;
    assign request.addr  = addr_reg;

    // Response counter saturated, no room for another response
    assign lane_busy = (state == lanes_pkg::LANE_ISSUE) && (&received);

    // Drops as soon as a descriptor is seen
    assign lane_done = idle_like && !descriptor.valid;

    // ------------------------------------------------
    // State machine and counters
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            state    <= lanes_pkg::LANE_IDLE;
            issued   <= '0;
            received <= '0;
        end else begin
            // Responses may come back while still issuing
            if (resp_hit) begin
                received <= received + 1'b1;
            end
            case (state)
                lanes_pkg::LANE_IDLE, lanes_pkg::LANE_DONE: begin
                    if (descriptor.valid) begin
                        issued   <= '0;
                        received <= '0;
                        // Empty run finishes at once
                        state    <= (descriptor.count == '0) ? lanes_pkg::LANE_DONE
                                                             : lanes_pkg::LANE_ISSUE;
                    end
                end
                lanes_pkg::LANE_ISSUE: begin
                    if (grant) begin
                        issued <= issued + 1'b1;
                        if (issued + 1'b1 == total) begin
                            state <= lanes_pkg::LANE_WAIT;
                        end
                    end
                end
                lanes_pkg::LANE_WAIT: begin
                    if (received == total) begin
                        state <= lanes_pkg::LANE_DONE;
                    end
                end
                default: state <= lanes_pkg::LANE_IDLE;
            endcase
        end
    end

    // Run address and length
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            addr_reg <= descriptor.base
                      + lanes_pkg::mem_addr_t'(LANE_ID) * lanes_pkg::LANE_STRIDE;
            total    <= descriptor.count;
        end else if ((state == lanes_pkg::LANE_ISSUE) && grant) begin
            addr_reg <= addr_reg + lanes_pkg::WORD_BYTES;
        end
    end

endmodule : lane_engine

/* request_arbiter.sv */
// Round-robin request arbiter
// Merges lane requests into one registered stream, held off by prog_full
`timescale 1ns/1ns

module request_arbiter (
    input  logic                    ap_clk,
    input  logic                    areset_lanes,
    input  lanes_pkg::mem_request_t lane_requests [lanes_pkg::NUM_LANES],
    output logic [lanes_pkg::NUM_LANES-1:0] grants,
    input  logic                    fifo_prog_full,
    output lanes_pkg::mem_request_t merged
);

    lanes_pkg::lane_id_t prio_ptr;
    lanes_pkg::lane_id_t cand_idx;
    lanes_pkg::lane_id_t winner;
    logic                found;
    logic                grant_any;

    // ------------------------------------------------
    // Winner search, starting at the priority pointer
    // ------------------------------------------------
    always_comb begin
        found    = 1'b0;
        winner   = prio_ptr;
        cand_idx = prio_ptr;
        for (int k = 0; k < lanes_pkg::NUM_LANES; k++) begin
            // Index wraps at the lane id width
            cand_idx = prio_ptr + lanes_pkg::lane_id_t'(k);
            if (!found && lane_requests[cand_idx].valid) begin
                found  = 1'b1;
                winner = cand_idx;
            end
        end
    end

    // No grant while the output FIFO is near full
    assign grant_any = found && !fifo_prog_full;

    always_comb begin
        grants = '0;
        if (grant_any) begin
            grants[winner] = 1'b1;
        end
    end

    // ------------------------------------------------
    // Pointer and registered merge
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            prio_ptr     <= '0;
            merged.valid <= 1'b0;
        end else begin
            merged.valid <= grant_any;
            // Next search starts just past the winner
            if (grant_any) begin
                prio_ptr <= winner + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        merged.id   <= lane_requests[winner].id;
        merged.addr <= lane_requests[winner].addr;
    end

endmodule : request_arbiter

/* response_router.sv */
// Response router
// Holds one memory response and delivers it to the lane named by its id
`timescale 1ns/1ns

module response_router (
    input  logic                     ap_clk,
    input  logic                     areset_lanes,
    input  lanes_pkg::mem_response_t response,
    output logic                     ready,
    input  logic [lanes_pkg::NUM_LANES-1:0] lane_busy,
    output lanes_pkg::mem_response_t lane_responses [lanes_pkg::NUM_LANES]
);

    lanes_pkg::mem_response_t held;

    // Free slot, or the held one leaves this cycle
    assign ready = !held.valid || !lane_busy[held.id];

    // Payload fans out, valid only on the target lane
    always_comb begin
        for (int i = 0; i < lanes_pkg::NUM_LANES; i++) begin
            lane_responses[i]       = held;
            lane_responses[i].valid = held.valid && !lane_busy[i]
                                    && (held.id == lanes_pkg::lane_id_t'(i));
        end
    end

    // Holding register
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            held.valid <= 1'b0;
        end else if (ready) begin
            held.valid <= response.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (ready) begin
            held.id   <= response.id;
            held.data <= response.data;
        end
    end

endmodule : response_router

/* bundle_lanes.sv */
// Lane bundle top level
// Broadcasts a descriptor to all lanes and shares one memory port between them
`timescale 1ns/1ns

module bundle_lanes (
    input  logic                     ap_clk,
    input  logic                     areset_lanes,
    input  lanes_pkg::descriptor_t   descriptor_in,
    input  lanes_pkg::mem_response_t response_memory_in,
    output lanes_pkg::mem_request_t  request_memory_out,
    input  logic                     request_rd_en,
    output logic                     response_prog_full,
    output logic                     done_out
);

    localparam int REQ_W = lanes_pkg::LANE_ID_W + lanes_pkg::ADDR_W;
    localparam int RSP_W = lanes_pkg::LANE_ID_W + lanes_pkg::DATA_W;

    lanes_pkg::descriptor_t   descriptor_in_reg;
    lanes_pkg::descriptor_t   lane_descriptor;
    lanes_pkg::mem_response_t response_in_reg;

    // Request side
    lanes_pkg::mem_request_t  lane_requests [lanes_pkg::NUM_LANES];
    logic [lanes_pkg::NUM_LANES-1:0] lane_grants;
    lanes_pkg::mem_request_t  merged;
    logic [REQ_W-1:0]         req_fifo_dout;
    logic                     req_fifo_valid;
    logic                     req_fifo_empty;
    logic                     req_fifo_prog_full;

    // Response side
    lanes_pkg::mem_response_t lane_responses [lanes_pkg::NUM_LANES];
    lanes_pkg::mem_response_t routed_in;
    logic [lanes_pkg::NUM_LANES-1:0] lane_busy;
    logic [lanes_pkg::NUM_LANES-1:0] lane_done;
    logic [RSP_W-1:0]         rsp_fifo_dout;
    logic                     rsp_fifo_valid;
    logic                     rsp_fifo_empty;
    logic                     router_ready;

    // ------------------------------------------------
    // Input registers and descriptor broadcast
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            descriptor_in_reg.valid <= 1'b0;
            lane_descriptor.valid   <= 1'b0;
            response_in_reg.valid   <= 1'b0;
        end else begin
            descriptor_in_reg.valid <= descriptor_in.valid;
            lane_descriptor.valid   <= descriptor_in_reg.valid;
            response_in_reg.valid   <= response_memory_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_in_reg.base  <= descriptor_in.base;
        descriptor_in_reg.count <= descriptor_in.count;
        lane_descriptor.base    <= descriptor_in_reg.base;
        lane_descriptor.count   <= descriptor_in_reg.count;
        response_in_reg.id      <= response_memory_in.id;
        response_in_reg.data    <= response_memory_in.data;
    end

    // All lanes idle or finished, all idle after reset
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            done_out <= 1'b1;
        end else begin
            done_out <= &lane_done;
        end
    end

    // ------------------------------------------------
    // Request path, arbiter into output FIFO
    // ------------------------------------------------
    request_arbiter u_arbiter (
        .ap_clk        (ap_clk),
        .areset_lanes  (areset_lanes),
        .lane_requests (lane_requests),
        .grants        (lane_grants),
        .fifo_prog_full(req_fifo_prog_full),
        .merged        (merged)
    );

    // Pops only while the memory side allows it
    sync_fifo #(
        .DEPTH(lanes_pkg::FIFO_DEPTH),
        .WIDTH(REQ_W)
    ) u_req_fifo (
        .ap_clk      (ap_clk),
        .areset_lanes(areset_lanes),
        .din         ({merged.id, merged.addr}),
        .wr_en       (merged.valid),
        .rd_en       (!req_fifo_empty && request_rd_en),
        .dout        (req_fifo_dout),
        .valid       (req_fifo_valid),
        .empty       (req_fifo_empty),
        .full        (),
        .prog_full   (req_fifo_prog_full)
    );

    assign request_memory_out = {req_fifo_valid, req_fifo_dout};

    // ------------------------------------------------
    // Response path, input FIFO into router
    // ------------------------------------------------
    sync_fifo #(
        .DEPTH(lanes_pkg::FIFO_DEPTH),
        .WIDTH(RSP_W)
    ) u_rsp_fifo (
        .ap_clk      (ap_clk),
        .areset_lanes(areset_lanes),
        .din         ({response_in_reg.id, response_in_reg.data}),
        .wr_en       (response_in_reg.valid),
        .rd_en       (!rsp_fifo_empty && router_ready),
        .dout        (rsp_fifo_dout),
        .valid       (rsp_fifo_valid),
        .empty       (rsp_fifo_empty),
        .full        (),
        .prog_full   (response_prog_full)
    );

    assign routed_in = {rsp_fifo_valid, rsp_fifo_dout};

    response_router u_router (
        .ap_clk        (ap_clk),
        .areset_lanes  (areset_lanes),
        .response      (routed_in),
        .ready         (router_ready),
        .lane_busy     (lane_busy),
        .lane_responses(lane_responses)
    );

    // ------------------------------------------------
    // Lanes
    // ------------------------------------------------
    for (genvar i = 0; i < lanes_pkg::NUM_LANES; i++) begin : gen_lanes
        lane_engine #(
            .LANE_ID(lanes_pkg::lane_id_t'(i))
        ) u_lane (
            .ap_clk      (ap_clk),
            .areset_lanes(areset_lanes),
            .descriptor  (lane_descriptor),
            .request     (lane_requests[i]),
            .grant       (lane_grants[i]),
            .response    (lane_responses[i]),
            .lane_busy   (lane_busy[i]),
            .lane_done   (lane_done[i])
        );
    end

endmodule : bundle_lanes

/* bundle_lanes_chk.sv */
// Lane bundle protocol checks
// Bound onto the top level, watches the pop strobe, done_out and request ids
`timescale 1ns/1ns

module bundle_lanes_chk (
    input logic                    ap_clk,
    input logic                    areset_lanes,
    input lanes_pkg::mem_request_t request_memory_out,
    input logic                    request_rd_en,
    input logic                    done_out
);

    int assert_fails = 0;

    // --------------------------------------------------
    // Output FIFO pop strobe
    // --------------------------------------------------
    // Valid only one cycle after a permitted pop
    a_pop_follows_rd_en: assert property (@(posedge ap_clk) disable iff (areset_lanes)
        request_memory_out.valid |-> $past(request_rd_en))
    else begin
        $error("request_memory_out.valid without request_rd_en one cycle earlier");
        assert_fails++;
    end

    // All lanes idle count as finished
    a_done_at_release: assert property (@(posedge ap_clk)
        $fell(areset_lanes) |-> done_out)
    else begin
        $error("done_out low at reset release");
        assert_fails++;
    end

    // Request tag names a real lane
    a_id_in_range: assert property (@(posedge ap_clk) disable iff (areset_lanes)
        request_memory_out.valid |->
            !$isunknown(request_memory_out.id) && (request_memory_out.id < lanes_pkg::NUM_LANES))
    else begin
        $error("request id out of range");
        assert_fails++;
    end

endmodule : bundle_lanes_chk

/* tb_bundle_lanes.sv */
// Lane bundle testbench
// Descriptor table, memory model and request checks against the address rule
`timescale 1ns/1ns

module tb_bundle_lanes;

    localparam int NUM_ENTRIES     = 6;
    localparam int DONE_FALL_LIMIT = 10;
    localparam int DONE_RISE_LIMIT = 3000;

    // One table row, stall is the rd_en low stretch in cycles
    typedef struct packed {
        logic [31:0] base;
        logic [7:0]  count;
        logic [7:0]  stall;
    } stim_entry_t;

    logic                     ap_clk;
    logic                     areset_lanes;
    lanes_pkg::descriptor_t   descriptor_in;
    lanes_pkg::mem_response_t response_memory_in;
    lanes_pkg::mem_request_t  request_memory_out;
    logic                     request_rd_en;
    logic                     response_prog_full;
    logic                     done_out;

    stim_entry_t              stim_table [NUM_ENTRIES];
    lanes_pkg::mem_request_t  pending [$];
    int                       seen_cnt [lanes_pkg::NUM_LANES][256];
    logic [31:0]              cur_base;
    int                       cur_count;
    int                       req_total;
    int                       rsp_total;
    int                       stall_left;
    int                       errors;
    int                       checks;
    logic                     timed_out;

    bundle_lanes UUT (
        .ap_clk            (ap_clk),
        .areset_lanes      (areset_lanes),
        .descriptor_in     (descriptor_in),
        .response_memory_in(response_memory_in),
        .request_memory_out(request_memory_out),
        .request_rd_en     (request_rd_en),
        .response_prog_full(response_prog_full),
        .done_out          (done_out)
    );

    bind bundle_lanes bundle_lanes_chk u_chk (
        .ap_clk            (ap_clk),
        .areset_lanes      (areset_lanes),
        .request_memory_out(request_memory_out),
        .request_rd_en     (request_rd_en),
        .done_out          (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Checks and run end
    // --------------------------------------------------
    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic finish_run;
        int total_errors;
        total_errors = errors + UUT.u_chk.assert_fails;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.u_chk.assert_fails);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // Poll done_out at each edge until it reaches level
    task automatic wait_done(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (done_out !== level && cycles < limit) begin
            @(posedge ap_clk);
            cycles++;
        end
        if (done_out !== level) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: done_out never went to %0b during %s", level, what);
        end
    endtask

    // --------------------------------------------------
    // Background processes
    // --------------------------------------------------
    // Random pop permission, held low during a stall stretch
    task automatic drive_rd_en;
        forever begin
            @(posedge ap_clk);
            if (stall_left > 0) begin
                stall_left--;
                request_rd_en <= 1'b0;
            end else begin
                request_rd_en <= ($urandom_range(0, 3) != 0);
            end
        end
    endtask

    // Decode each popped request back into lane and word index
    task automatic watch_requests;
        logic [31:0] offset;
        int          lane;
        int          word;
        logic        in_run;
        forever begin
            @(posedge ap_clk);
            if (request_memory_out.valid === 1'b1) begin
                offset = request_memory_out.addr - cur_base;
                lane   = offset / lanes_pkg::LANE_STRIDE;
                word   = (offset % lanes_pkg::LANE_STRIDE) / lanes_pkg::WORD_BYTES;
                in_run = (lane < lanes_pkg::NUM_LANES) && (word < cur_count);
                req_total++;
                pending.push_back(request_memory_out);
                check_equal(offset % lanes_pkg::WORD_BYTES, 0, "request word aligned");
                check_equal({31'b0, in_run}, 1, "request inside current run");
                if (in_run) begin
                    check_equal(request_memory_out.id, lane, "request id matches address");
                    seen_cnt[lane][word]++;
                end
            end
        end
    endtask

    // Memory model, answers in order with data of address plus one
    task automatic respond_memory;
        lanes_pkg::mem_request_t req;
        int                      gap;
        gap = 0;
        forever begin
            @(posedge ap_clk);
            if (gap == 0 && pending.size() > 0 && !response_prog_full) begin
                req = pending.pop_front();
                response_memory_in <= '{valid: 1'b1, id: req.id, data: req.addr + 32'd1};
                rsp_total++;
                gap = $urandom_range(0, 4);
            end else begin
                response_memory_in <= '0;
                if (gap > 0) begin
                    gap--;
                end
            end
        end
    endtask

    // --------------------------------------------------
    // One descriptor run
    // --------------------------------------------------
    task automatic apply_entry(input stim_entry_t entry);
        foreach (seen_cnt[l, k]) begin
            seen_cnt[l][k] = 0;
        end
        cur_base  = entry.base;
        cur_count = entry.count;
        req_total = 0;
        rsp_total = 0;
        @(posedge ap_clk);
        descriptor_in <= '{valid: 1'b1, base: entry.base, count: entry.count};
        stall_left = entry.stall;
        @(posedge ap_clk);
        descriptor_in <= '0;
        wait_done(1'b0, DONE_FALL_LIMIT, "descriptor start");
        if (!timed_out) begin
            wait_done(1'b1, DONE_RISE_LIMIT, "run completion");
        end
        if (!timed_out) begin
            // Every lane issued and got back exactly count words
            check_equal(req_total, lanes_pkg::NUM_LANES * entry.count, "requests per run");
            check_equal(rsp_total, req_total, "responses sent before done");
            check_equal(response_prog_full, 1'b0, "response FIFO drained at done");
            for (int l = 0; l < lanes_pkg::NUM_LANES; l++) begin
                for (int k = 0; k < entry.count; k++) begin
                    check_equal(seen_cnt[l][k], 1,
                                $sformatf("lane %0d word %0d seen once", l, k));
                end
            end
        end
    endtask

    initial begin
        areset_lanes       = 1'b1;
        descriptor_in      = '0;
        response_memory_in = '0;
        request_rd_en      = 1'b0;
        cur_base           = '0;
        cur_count          = 0;
        stall_left         = 0;
        errors             = 0;
        checks             = 0;
        timed_out          = 1'b0;
        void'($urandom(32'h8f7f_7aa8));

        // Base, count, rd_en stall
        stim_table[0] = '{base: 32'h0001_0000, count: 8'd1, stall: 8'd0};
        stim_table[1] = '{base: 32'h0002_0040, count: 8'd4, stall: 8'd0};
        stim_table[2] = '{base: 32'h0003_0000, count: 8'd3, stall: 8'd0};
        stim_table[3] = '{base: 32'h0004_0100, count: 8'd4, stall: 8'd60};
        stim_table[4] = '{base: 32'h0005_0000, count: 8'd0, stall: 8'd0};
        stim_table[5] = '{base: 32'h0006_0ffc, count: 8'd2, stall: 8'd20};

        // Child processes draw from the seeded generator
        fork
            drive_rd_en();
            watch_requests();
            respond_memory();
        join_none

        repeat (8) @(posedge ap_clk);
        areset_lanes <= 1'b0;

        // Idle bundle after reset
        repeat (10) begin
            @(posedge ap_clk);
            check_equal(done_out, 1'b1, "done_out high after reset");
            check_equal(request_memory_out.valid, 1'b0, "no request after reset");
            check_equal(response_prog_full, 1'b0, "response_prog_full low after reset");
        end

        for (int i = 0; i < NUM_ENTRIES && !timed_out; i++) begin
            apply_entry(stim_table[i]);
        end

        repeat (20) @(posedge ap_clk);
        finish_run();
    end

endmodule : tb_bundle_lanes

/* project.f */
lanes_pkg.sv
sync_fifo.sv
lane_engine.sv
request_arbiter.sv
response_router.sv
bundle_lanes.sv
bundle_lanes_chk.sv
tb_bundle_lanes.sv

/* Bender.yml */
package:
  name: bundle_lanes

sources:
  - lanes_pkg.sv
  - sync_fifo.sv
  - lane_engine.sv
  - request_arbiter.sv
  - response_router.sv
  - bundle_lanes.sv
  - target: test
    files:
      - bundle_lanes_chk.sv
      - tb_bundle_lanes.sv
